//--- logic/vga_pkg.sv
/*
  VGA pattern package
  Shared count and pattern code types, pattern code values and the
  lock state encoding for the test pattern subsystem
*/
package vga_pkg;

  // Column or row count, wide enough for 800 total columns
  typedef logic [9:0] count_t;

  // Pattern selection code
  typedef logic [3:0] pattern_t;

  //////////////////////////////////////////////////
  // Pattern codes
  //////////////////////////////////////////////////
  // Codes 7 to 15 are treated as off
  localparam pattern_t PAT_OFF     = 4'd0;
  localparam pattern_t PAT_RED     = 4'd1;
  localparam pattern_t PAT_GREEN   = 4'd2;
  localparam pattern_t PAT_BLUE    = 4'd3;
  localparam pattern_t PAT_CHECKER = 4'd4;
  localparam pattern_t PAT_BARS    = 4'd5;
  localparam pattern_t PAT_BORDER  = 4'd6;

  // Lock FSM of the sync-to-count block
  typedef enum logic
  {
    LOCK_SEARCH,
    LOCK_TRACK
  } lock_state_t;

endpackage

//--- logic/sync_gen.sv
/*
  Sync generator
  Free-running column and row counters that stand in for a video source
  and emit registered sync levels, high inside the active area
*/
`timescale 1ns/1ps

module sync_gen
#(
  parameter int TOTAL_COLS  = 800,
  parameter int TOTAL_ROWS  = 525,
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480
)
(
  input  logic i_Clk,
  input  logic i_reset,
  output logic o_hsync,
  output logic o_vsync
);

  // Frame limits as count values
  localparam vga_pkg::count_t LAST_COL = vga_pkg::count_t'(TOTAL_COLS - 1);
  localparam vga_pkg::count_t LAST_ROW = vga_pkg::count_t'(TOTAL_ROWS - 1);
  localparam vga_pkg::count_t ACT_COLS = vga_pkg::count_t'(ACTIVE_COLS);
  localparam vga_pkg::count_t ACT_ROWS = vga_pkg::count_t'(ACTIVE_ROWS);

  vga_pkg::count_t col;
  vga_pkg::count_t row;

  //////////////////////////////////////////////////
  // Raster counters
  //////////////////////////////////////////////////
  // Column wraps at the end of a line, row steps on each wrap
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      col <= '0;
      row <= '0;
    end
    else
    begin
      if (col == LAST_COL)
      begin
        col <= '0;
        // Row wraps at the end of the frame
        if (row == LAST_ROW)
        begin
          row <= '0;
        end
        else
        begin
          row <= row + vga_pkg::count_t'(1);
        end
      end
      else
      begin
        col <= col + vga_pkg::count_t'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Sync levels
  //////////////////////////////////////////////////
  // Registered, so each sync trails its counter by one cycle
  // Both syncs describe the same raster position
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      o_hsync <= 1'b0;
      o_vsync <= 1'b0;
    end
    else
    begin
      // High while inside the active columns
      o_hsync <= (col < ACT_COLS);
      // High while inside the active rows
      o_vsync <= (row < ACT_ROWS);
    end
  end

endmodule

//--- logic/sync_to_count.sv
/*
  Sync to count
  Recovers column and row counts from incoming sync levels, with a
  frame start pulse, delayed syncs and a lock flag
*/
`timescale 1ns/1ps

module sync_to_count
#(
  parameter int TOTAL_COLS = 800,
  parameter int TOTAL_ROWS = 525
)
(
  input  logic            i_Clk,
  input  logic            i_reset,
  input  logic            i_hsync,
  input  logic            i_vsync,
  output logic            o_hsync,
  output logic            o_vsync,
  output vga_pkg::count_t o_col,
  output vga_pkg::count_t o_row,
  output logic            o_frame_start,
  output logic            o_locked
);

  localparam vga_pkg::count_t LAST_COL = vga_pkg::count_t'(TOTAL_COLS - 1);
  localparam vga_pkg::count_t LAST_ROW = vga_pkg::count_t'(TOTAL_ROWS - 1);

  vga_pkg::lock_state_t lock_state;
  logic                 vsync_rise;

  // Delayed vsync doubles as the edge detector history
  assign vsync_rise = i_vsync & ~o_vsync;

  //////////////////////////////////////////////////
  // Sync delay and frame start
  //////////////////////////////////////////////////
  // One cycle delay so syncs line up with the counts
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      o_hsync       <= 1'b0;
      o_vsync       <= 1'b0;
      o_frame_start <= 1'b0;
    end
    else
    begin
      o_hsync       <= i_hsync;
      o_vsync       <= i_vsync;
      // Pulse in the cycle the counts read 0,0
      o_frame_start <= vsync_rise;
    end
  end

  //////////////////////////////////////////////////
  // Column and row counters
  //////////////////////////////////////////////////
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      o_col <= '0;
      o_row <= '0;
    end
    else if (vsync_rise)
    begin
      // Vsync rise marks the first pixel of a frame
      o_col <= '0;
      o_row <= '0;
    end
    else if (o_col == LAST_COL)
    begin
      o_col <= '0;
      o_row <= (o_row == LAST_ROW) ? '0 : o_row + vga_pkg::count_t'(1);
    end
    else
    begin
      o_col <= o_col + vga_pkg::count_t'(1);
    end
  end

  //////////////////////////////////////////////////
  // Lock FSM
  //////////////////////////////////////////////////
  // Searches for the first frame start, then tracks until reset
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      lock_state <= vga_pkg::LOCK_SEARCH;
    end
    else if (lock_state == vga_pkg::LOCK_SEARCH && vsync_rise)
    begin
      lock_state <= vga_pkg::LOCK_TRACK;
    end
  end

  // Rises together with the first frame start pulse
  assign o_locked = (lock_state == vga_pkg::LOCK_TRACK);

endmodule

//--- logic/pattern_config.sv
/*
  Pattern configuration
  Host-written pending pattern, moved to the active copy only at a
  frame start so that a frame never mixes two patterns
*/
`timescale 1ns/1ps

module pattern_config
(
  input  logic              i_Clk,
  input  logic              i_reset,
  input  vga_pkg::pattern_t i_pattern,
  input  logic              i_pattern_wr,
  input  logic              i_frame_start,
  output vga_pkg::pattern_t o_active_pattern
);

  // Last value written by the host
  vga_pkg::pattern_t pending_pattern;
  // Selection of the frame in progress
  vga_pkg::pattern_t active_pattern;

  //////////////////////////////////////////////////
  // Pending register
  //////////////////////////////////////////////////
  // Loaded on the write strobe, visible next cycle
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      pending_pattern <= vga_pkg::PAT_OFF;
    end
    else if (i_pattern_wr)
    begin
      pending_pattern <= i_pattern;
    end
  end

  //////////////////////////////////////////////////
  // Active register
  //////////////////////////////////////////////////
  // Updated only on frame start, holds for the whole frame
  // A write in the frame start cycle waits for the next frame
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      active_pattern <= vga_pkg::PAT_OFF;
    end
    else if (i_frame_start)
    begin
      active_pattern <= pending_pattern;
    end
  end

  // Frame start cycle already carries the new selection
  // First pixel of a frame matches the rest of it
  assign o_active_pattern = i_frame_start ? pending_pattern : active_pattern;

endmodule

//--- logic/test_pattern_gen.sv
/*
  Test pattern generator
  Computes all seven test patterns in parallel from the pixel counts
  and registers the selected one together with the syncs and lock
*/
`timescale 1ns/1ps

module test_pattern_gen
#(
  parameter int ACTIVE_COLS     = 640,
  parameter int ACTIVE_ROWS     = 480,
  parameter int COMPONENT_DEPTH = 8,
  parameter int CHECKER_BIT     = 5
)
(
  input  logic                       i_Clk,
  input  logic                       i_reset,
  input  vga_pkg::count_t            i_col,
  input  vga_pkg::count_t            i_row,
  input  logic                       i_hsync,
  input  logic                       i_vsync,
  input  logic                       i_locked,
  input  vga_pkg::pattern_t          i_pattern,
  output logic                       o_hsync,
  output logic                       o_vsync,
  output logic                       o_locked,
  output logic [COMPONENT_DEPTH-1:0] o_red,
  output logic [COMPONENT_DEPTH-1:0] o_grn,
  output logic [COMPONENT_DEPTH-1:0] o_blu
);

  // Active area limits
  localparam vga_pkg::count_t ACT_COLS = vga_pkg::count_t'(ACTIVE_COLS);
  localparam vga_pkg::count_t ACT_ROWS = vga_pkg::count_t'(ACTIVE_ROWS);
  // First column and row of the right and bottom border strips
  localparam vga_pkg::count_t EDGE_COL = vga_pkg::count_t'(ACTIVE_COLS - 2);
  localparam vga_pkg::count_t EDGE_ROW = vga_pkg::count_t'(ACTIVE_ROWS - 2);
  // Eight equal bars across the active width
  localparam int BAR_WIDTH = ACTIVE_COLS / 8;

  logic       active;
  logic       checker_on;
  logic       border_on;
  logic [2:0] bar_idx;
  // Per pattern on/off flags, bit 2 red, bit 1 green, bit 0 blue
  logic [2:0] rgb_red;
  logic [2:0] rgb_grn;
  logic [2:0] rgb_blu;
  logic [2:0] rgb_checker;
  logic [2:0] rgb_bars;
  logic [2:0] rgb_border;
  logic [2:0] rgb_sel;

  assign active = (i_col < ACT_COLS) && (i_row < ACT_ROWS);

  //////////////////////////////////////////////////
  // Solid colours
  //////////////////////////////////////////////////
  // Outside the active area the output stage blanks anyway
  assign rgb_red = 3'b100;
  assign rgb_grn = 3'b010;
  assign rgb_blu = 3'b001;

  //////////////////////////////////////////////////
  // Checkerboard
  //////////////////////////////////////////////////
  // Square size is 2**CHECKER_BIT pixels
  assign checker_on  = i_col[CHECKER_BIT] ^ i_row[CHECKER_BIT];
  assign rgb_checker = {3{checker_on}};

  //////////////////////////////////////////////////
  // Colour bars
  //////////////////////////////////////////////////
  // Bar index is column / BAR_WIDTH, clamped to 7
  // Compare chain avoids a real divider
  always_comb
  begin
    bar_idx = 3'd0;
    for (int i = 1; i < 8; i++)
    begin
      if (i_col >= vga_pkg::count_t'(i * BAR_WIDTH))
      begin
        bar_idx = 3'(i);
      end
    end
  end

  // Index bits map straight onto red, green, blue
  // 0 black, 1 blue, 2 green, 3 cyan, 4 red, 5 magenta, 6 yellow, 7 white
  assign rgb_bars = bar_idx;

  //////////////////////////////////////////////////
  // White border, 2 pixels
  //////////////////////////////////////////////////
  assign border_on = (i_row <= vga_pkg::count_t'(1)) || (i_row >= EDGE_ROW) ||
                     (i_col <= vga_pkg::count_t'(1)) || (i_col >= EDGE_COL);
  assign rgb_border = {3{border_on}};

  //////////////////////////////////////////////////
  // Pattern select
  //////////////////////////////////////////////////
  always_comb
  begin
    case (i_pattern)
      vga_pkg::PAT_RED:     rgb_sel = rgb_red;
      vga_pkg::PAT_GREEN:   rgb_sel = rgb_grn;
      vga_pkg::PAT_BLUE:    rgb_sel = rgb_blu;
      vga_pkg::PAT_CHECKER: rgb_sel = rgb_checker;
      vga_pkg::PAT_BARS:    rgb_sel = rgb_bars;
      vga_pkg::PAT_BORDER:  rgb_sel = rgb_border;
      // Off and unused codes give black
      default:              rgb_sel = 3'b000;
    endcase
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////
  // Colour, syncs and lock share one stage so they stay aligned
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      o_hsync  <= 1'b0;
      o_vsync  <= 1'b0;
      o_locked <= 1'b0;
      o_red    <= '0;
      o_grn    <= '0;
      o_blu    <= '0;
    end
    else
    begin
      o_hsync  <= i_hsync;
      o_vsync  <= i_vsync;
      o_locked <= i_locked;
      // Blank outside the active area and until lock
      if (active && i_locked)
      begin
        o_red <= {COMPONENT_DEPTH{rgb_sel[2]}};
        o_grn <= {COMPONENT_DEPTH{rgb_sel[1]}};
        o_blu <= {COMPONENT_DEPTH{rgb_sel[0]}};
      end
      else
      begin
        o_red <= '0;
        o_grn <= '0;
        o_blu <= '0;
      end
    end
  end

endmodule

//--- logic/vga_pattern_top.sv
/*
  VGA test pattern top level
  Sync source, count recovery, pattern configuration and pattern generator
*/
`timescale 1ns/1ps

module vga_pattern_top
#(
  parameter int TOTAL_COLS      = 800,
  parameter int TOTAL_ROWS      = 525,
  parameter int ACTIVE_COLS     = 640,
  parameter int ACTIVE_ROWS     = 480,
  parameter int COMPONENT_DEPTH = 8,
  parameter int CHECKER_BIT     = 5
)
(
  input  logic                       i_Clk,
  input  logic                       i_reset,
  input  vga_pkg::pattern_t          i_pattern,
  input  logic                       i_pattern_wr,
  output logic                       o_locked,
  output logic                       o_hsync,
  output logic                       o_vsync,
  output logic [COMPONENT_DEPTH-1:0] o_red,
  output logic [COMPONENT_DEPTH-1:0] o_grn,
  output logic [COMPONENT_DEPTH-1:0] o_blu
);

  // Raw syncs from the source
  logic raw_hsync;
  logic raw_vsync;
  // Syncs aligned with the recovered counts
  logic cnt_hsync;
  logic cnt_vsync;
  logic frame_start;
  logic locked;
  vga_pkg::count_t   col;
  vga_pkg::count_t   row;
  vga_pkg::pattern_t active_pattern;

  sync_gen #(
    .TOTAL_COLS  (TOTAL_COLS),
    .TOTAL_ROWS  (TOTAL_ROWS),
    .ACTIVE_COLS (ACTIVE_COLS),
    .ACTIVE_ROWS (ACTIVE_ROWS)
  ) u_sync_gen (
    .i_Clk   (i_Clk),
    .i_reset (i_reset),
    .o_hsync (raw_hsync),
    .o_vsync (raw_vsync)
  );

  sync_to_count #(
    .TOTAL_COLS (TOTAL_COLS),
    .TOTAL_ROWS (TOTAL_ROWS)
  ) u_sync_to_count (
    .i_Clk         (i_Clk),
    .i_reset       (i_reset),
    .i_hsync       (raw_hsync),
    .i_vsync       (raw_vsync),
    .o_hsync       (cnt_hsync),
    .o_vsync       (cnt_vsync),
    .o_col         (col),
    .o_row         (row),
    .o_frame_start (frame_start),
    .o_locked      (locked)
  );

  pattern_config u_pattern_config (
    .i_Clk            (i_Clk),
    .i_reset          (i_reset),
    .i_pattern        (i_pattern),
    .i_pattern_wr     (i_pattern_wr),
    .i_frame_start    (frame_start),
    .o_active_pattern (active_pattern)
  );

  test_pattern_gen #(
    .ACTIVE_COLS     (ACTIVE_COLS),
    .ACTIVE_ROWS     (ACTIVE_ROWS),
    .COMPONENT_DEPTH (COMPONENT_DEPTH),
    .CHECKER_BIT     (CHECKER_BIT)
  ) u_test_pattern_gen (
    .i_Clk     (i_Clk),
    .i_reset   (i_reset),
    .i_col     (col),
    .i_row     (row),
    .i_hsync   (cnt_hsync),
    .i_vsync   (cnt_vsync),
    .i_locked  (locked),
    .i_pattern (active_pattern),
    .o_hsync   (o_hsync),
    .o_vsync   (o_vsync),
    .o_locked  (o_locked),
    .o_red     (o_red),
    .o_grn     (o_grn),
    .o_blu     (o_blu)
  );

endmodule

//--- sim/vga_pattern_asserts.sv
/*
  VGA pattern port checks
  Concurrent assertions on lock and blanking, bound to the top level
*/
`timescale 1ns/1ps

module vga_pattern_asserts
#(
  parameter int COMPONENT_DEPTH = 8
)
(
  input logic                       i_Clk,
  input logic                       i_reset,
  input logic                       i_locked,
  input logic                       i_hsync,
  input logic                       i_vsync,
  input logic [COMPONENT_DEPTH-1:0] i_red,
  input logic [COMPONENT_DEPTH-1:0] i_grn,
  input logic [COMPONENT_DEPTH-1:0] i_blu
);

  logic colour_zero;

  assign colour_zero = (i_red == '0) && (i_grn == '0) && (i_blu == '0);

  // Lock holds until the next reset
  locked_held: assert property (@(posedge i_Clk) disable iff (i_reset)
    $past(i_locked) |-> i_locked)
    else $error("o_locked fell after it had risen");

  // Blanking intervals carry no colour
  blank_black: assert property (@(posedge i_Clk) disable iff (i_reset)
    (!i_hsync || !i_vsync) |-> colour_zero)
    else $error("Colour is not zero while a sync is low");

  // Nothing is drawn before lock
  unlocked_black: assert property (@(posedge i_Clk) disable iff (i_reset)
    !i_locked |-> colour_zero)
    else $error("Colour is not zero while o_locked is low");

endmodule

// Checks ride along with every top level instance
bind vga_pattern_top vga_pattern_asserts #(
  .COMPONENT_DEPTH (COMPONENT_DEPTH)
) u_vga_pattern_asserts (
  .i_Clk    (i_Clk),
  .i_reset  (i_reset),
  .i_locked (o_locked),
  .i_hsync  (o_hsync),
  .i_vsync  (o_vsync),
  .i_red    (o_red),
  .i_grn    (o_grn),
  .i_blu    (o_blu)
);

//--- sim/tb_vga_pattern.sv
/*
  VGA test pattern testbench
  Tracks the raster from the output syncs and checks every pixel
  against a reference model of the pattern rules
*/
`timescale 1ns/1ps

module tb_vga_pattern;

  // Small frame so that a full frame runs in 1200 cycles
  localparam int TOTAL_COLS      = 40;
  localparam int TOTAL_ROWS      = 30;
  localparam int ACTIVE_COLS     = 32;
  localparam int ACTIVE_ROWS     = 24;
  localparam int COMPONENT_DEPTH = 8;
  localparam int CHECKER_BIT     = 2;
  localparam int PIXEL_W         = 3 * COMPONENT_DEPTH;
  // Wait limit, two frames
  localparam int WAIT_LIMIT      = 2 * TOTAL_COLS * TOTAL_ROWS;

  logic                       i_Clk;
  logic                       i_reset;
  vga_pkg::pattern_t          i_pattern;
  logic                       i_pattern_wr;
  logic                       o_locked;
  logic                       o_hsync;
  logic                       o_vsync;
  logic [COMPONENT_DEPTH-1:0] o_red;
  logic [COMPONENT_DEPTH-1:0] o_grn;
  logic [COMPONENT_DEPTH-1:0] o_blu;

  // Raster position recovered from the output syncs
  int                 col_pos;
  int                 row_pos;
  int                 frame_count;
  logic               prev_vsync;
  logic               frame_edge;
  logic               synced;
  // Model copies of the pattern registers
  vga_pkg::pattern_t  model_pending;
  vga_pkg::pattern_t  model_active;
  logic [PIXEL_W-1:0] expected;
  logic [7:0]         lfsr;
  vga_pkg::pattern_t  code;

  vga_pattern_top #(
    .TOTAL_COLS      (TOTAL_COLS),
    .TOTAL_ROWS      (TOTAL_ROWS),
    .ACTIVE_COLS     (ACTIVE_COLS),
    .ACTIVE_ROWS     (ACTIVE_ROWS),
    .COMPONENT_DEPTH (COMPONENT_DEPTH),
    .CHECKER_BIT     (CHECKER_BIT)
  ) i_dut (
    .i_Clk        (i_Clk),
    .i_reset      (i_reset),
    .i_pattern    (i_pattern),
    .i_pattern_wr (i_pattern_wr),
    .o_locked     (o_locked),
    .o_hsync      (o_hsync),
    .o_vsync      (o_vsync),
    .o_red        (o_red),
    .o_grn        (o_grn),
    .o_blu        (o_blu)
  );

  // 40 ns period
  initial
  begin
    i_Clk = 1'b0;
    forever #20 i_Clk = ~i_Clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  // 8-bit Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int count, output vga_pkg::pattern_t value);
    value = vga_pkg::PAT_OFF;
    for (int i = 0; i < count; i++)
    begin
      lfsr  = lfsr_next(lfsr);
      value = {value[2:0], lfsr[0]};
    end
  endtask

  // Expected colour of one pixel, straight from the pattern rules
  function automatic logic [PIXEL_W-1:0] expected_pixel(input int col, input int row,
                                                        input vga_pkg::pattern_t pattern);
    logic [2:0] rgb;
    int         bar;
    rgb = 3'b000;
    // Eight bars, index clamped to 7
    bar = col / (ACTIVE_COLS / 8);
    if (bar > 7)
    begin
      bar = 7;
    end
    if (col < ACTIVE_COLS && row < ACTIVE_ROWS)
    begin
      case (pattern)
        vga_pkg::PAT_RED:     rgb = 3'b100;
        vga_pkg::PAT_GREEN:   rgb = 3'b010;
        vga_pkg::PAT_BLUE:    rgb = 3'b001;
        vga_pkg::PAT_CHECKER: rgb = {3{col[CHECKER_BIT] ^ row[CHECKER_BIT]}};
        vga_pkg::PAT_BARS:    rgb = bar[2:0];
        vga_pkg::PAT_BORDER:
        begin
          // 2 pixel white frame edge
          if (row <= 1 || row >= ACTIVE_ROWS - 2 || col <= 1 || col >= ACTIVE_COLS - 2)
          begin
            rgb = 3'b111;
          end
        end
        default:              rgb = 3'b000;
      endcase
    end
    return {{COMPONENT_DEPTH{rgb[2]}}, {COMPONENT_DEPTH{rgb[1]}}, {COMPONENT_DEPTH{rgb[0]}}};
  endfunction

  //////////////////////////////////////////////////
  // Waits, each with its own limit
  //////////////////////////////////////////////////
  task automatic wait_lock();
    int cycles;
    cycles = 0;
    while (!synced)
    begin
      if (cycles == WAIT_LIMIT)
        stop_with_failure("Timed out waiting for o_locked to rise");
      @(posedge i_Clk);
      cycles++;
    end
  endtask

  task automatic wait_frame();
    int start;
    int cycles;
    start  = frame_count;
    cycles = 0;
    while (frame_count == start)
    begin
      if (cycles == WAIT_LIMIT)
        stop_with_failure("Timed out waiting for the next frame start");
      @(posedge i_Clk);
      cycles++;
    end
  endtask

  task automatic wait_row(input int target);
    int cycles;
    cycles = 0;
    while (row_pos != target)
    begin
      if (cycles == WAIT_LIMIT)
        stop_with_failure("Timed out waiting for the middle of a frame");
      @(posedge i_Clk);
      cycles++;
    end
  endtask

  // Write in mid frame, then run into the frame that uses it
  task automatic show_pattern(input vga_pkg::pattern_t value);
    wait_row(ACTIVE_ROWS / 2);
    @(posedge i_Clk);
    i_pattern     <= value;
    i_pattern_wr  <= 1'b1;
    model_pending = value;
    @(posedge i_Clk);
    i_pattern_wr <= 1'b0;
    wait_frame();
  endtask

  //////////////////////////////////////////////////
  // Comparing process
  //////////////////////////////////////////////////
  // Samples at the falling edge, half a cycle after the outputs move
  always @(negedge i_Clk)
  begin
    if (i_reset !== 1'b0)
    begin
      col_pos      = 0;
      row_pos      = 0;
      frame_count  = 0;
      prev_vsync   = 1'b0;
      synced       = 1'b0;
      model_active = vga_pkg::PAT_OFF;
    end
    else
    begin
      // Same count rule as the count recovery
      frame_edge = o_vsync && !prev_vsync;
      prev_vsync = o_vsync;
      if (frame_edge)
      begin
        col_pos      = 0;
        row_pos      = 0;
        synced       = 1'b1;
        // New selection applies from the first pixel of the frame
        model_active = model_pending;
        frame_count  = frame_count + 1;
      end
      else if (col_pos == TOTAL_COLS - 1)
      begin
        col_pos = 0;
        row_pos = (row_pos == TOTAL_ROWS - 1) ? 0 : row_pos + 1;
      end
      else
      begin
        col_pos = col_pos + 1;
      end
      expected = synced ? expected_pixel(col_pos, row_pos, model_active) : '0;
      assert (o_locked == synced)
      else
        stop_with_failure($sformatf("Mismatch at %0t: o_locked is %b", $time, o_locked));
      if (synced)
      begin
        assert (o_hsync == (col_pos < ACTIVE_COLS) && o_vsync == (row_pos < ACTIVE_ROWS))
        else
          stop_with_failure($sformatf("Mismatch at %0t: syncs %b %b at col %0d row %0d",
                                      $time, o_hsync, o_vsync, col_pos, row_pos));
      end
      assert ({o_red, o_grn, o_blu} == expected)
      else
        stop_with_failure($sformatf("Mismatch at %0t: col %0d row %0d pattern %0d got %h want %h",
                                    $time, col_pos, row_pos, model_active,
                                    {o_red, o_grn, o_blu}, expected));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial
  begin
    i_reset       = 1'b1;
    i_pattern     = vga_pkg::PAT_OFF;
    i_pattern_wr  = 1'b0;
    model_pending = vga_pkg::PAT_OFF;
    lfsr          = 8'd39;
    repeat (7) @(posedge i_Clk);
    @(negedge i_Clk);
    assert ({o_locked, o_hsync, o_vsync, o_red, o_grn, o_blu} == '0)
    else
      stop_with_failure($sformatf("Mismatch at %0t: outputs not zero in reset", $time));
    // Eighth reset cycle, then release
    @(posedge i_Clk);
    i_reset <= 1'b0;
    wait_lock();
    // Every defined pattern for one full frame
    for (int p = 1; p <= 6; p++)
    begin
      show_pattern(vga_pkg::pattern_t'(p));
    end
    // Random codes over the whole range
    repeat (8)
    begin
      draw_bits(4, code);
      show_pattern(code);
    end
    // Unused codes give black
    show_pattern(4'd7);
    repeat (4)
    begin
      draw_bits(3, code);
      show_pattern({1'b1, code[2:0]});
    end
    // Last selection runs one more frame
    wait_frame();
    $display("Test passed");
    $finish;
  end

endmodule

//--- sim.f
logic/vga_pkg.sv
logic/sync_gen.sv
logic/sync_to_count.sv
logic/pattern_config.sv
logic/test_pattern_gen.sv
logic/vga_pattern_top.sv
sim/vga_pattern_asserts.sv
sim/tb_vga_pattern.sv

//--- Makefile
# Verilator build and run of the VGA pattern testbench

TOP := tb_vga_pattern

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
